// File: src/tx_pkg.sv
// 3-DW requests only: 32-bit qword-aligned addresses, even nonzero dword lengths
package tx_pkg;

  // streaming beat data width
  localparam int DATA_W = 64;

  // stored beat is {eop, sop, data}
  localparam int BEAT_W = DATA_W + 2;

  // command word read from the external command FIFO
  localparam int CMD_W = 60;

  // bus and device number, function is always zero
  localparam int BUSDEV_W = 13;

  // dword length field of the TLP header
  localparam int LEN_W = 10;

  // format/type byte of a 3-DW memory request
  localparam logic [7:0] FMT_MRD32 = 8'h00;
  localparam logic [7:0] FMT_MWR32 = 8'h40;

  // command word layout, addr sits in the top bits
  typedef struct packed {
    logic [31:0]      addr;
    logic             is_rd;
    logic             is_wr;
    logic [7:0]       tag;
    logic [3:0]       fbe;
    logic [3:0]       lbe;
    logic [LEN_W-1:0] dw_len;
  } tx_cmd_t;

endpackage

// File: src/tx_cmd_decode.sv
// cmd_data_i must stay stable from the cycle after the pop until the next pop
`timescale 1ns/10ps

module tx_cmd_decode import tx_pkg::*;
(
  input  logic                Clk_i,
  input  logic                Rstn_i,
  input  logic                capture_i,
  input  logic [CMD_W-1:0]    cmd_data_i,
  input  logic [BUSDEV_W-1:0] bus_dev_i,
  output logic                is_rd_o,
  output logic                is_wr_o,
  output logic [LEN_W-1:0]    dw_len_o,
  output logic [DATA_W-1:0]   hdr1_o,
  output logic [DATA_W-1:0]   hdr2_o
);

  tx_cmd_t    cmd_in;
  tx_cmd_t    cmd_q;
  tx_cmd_t    cmd_cur;
  logic [7:0] fmt;

  assign cmd_in = tx_cmd_t'(cmd_data_i);

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      cmd_q <= '0;
    end
    else if (capture_i)
    begin
      cmd_q <= cmd_in;
    end
  end

  // the controller decides in the capture cycle, so bypass the register then
  assign cmd_cur = capture_i ? cmd_in : cmd_q;

  assign is_rd_o  = cmd_cur.is_rd;
  assign is_wr_o  = cmd_cur.is_wr;
  assign dw_len_o = cmd_cur.dw_len;

  assign fmt = cmd_q.is_wr ? FMT_MWR32 : FMT_MRD32;

  // requester id, tag, byte enables, fmt/type, then zero tc/attr fields and length
  assign hdr1_o = {bus_dev_i, 3'b000, cmd_q.tag, cmd_q.lbe, cmd_q.fbe,
                   fmt, 14'h0, cmd_q.dw_len};

  // third header dword only, the upper dword is unused padding
  assign hdr2_o = {32'h0, cmd_q.addr};

  // the command source must never mark a request as both kinds
  a_kind_exclusive : assert property (
    @(posedge Clk_i) disable iff (!Rstn_i)
    capture_i |=> !(is_rd_o && is_wr_o)
  );

endmodule

// File: src/tx_ctrl.sv
// write payload FIFO output must hold until the next request, dw_len/2 >= 1 for writes
`timescale 1ns/10ps

module tx_ctrl import tx_pkg::*;
(
  input  logic              Clk_i,
  input  logic              Rstn_i,
  input  logic              cmd_empty_i,
  input  logic              is_rd_i,
  input  logic              is_wr_i,
  input  logic [LEN_W-1:0]  dw_len_i,
  input  logic [DATA_W-1:0] hdr1_i,
  input  logic [DATA_W-1:0] hdr2_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic              tag_avail_i,
  input  logic              room_i,
  output logic              cmd_rd_req_o,
  output logic              wr_rd_req_o,
  output logic              capture_o,
  output logic              read_issued_o,
  output logic              fifo_wr_o,
  output logic [BEAT_W-1:0] fifo_beat_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_CHECK,
    S_HDR1,
    S_HDR2,
    S_DATA,
    S_WAIT
  } state_t;

  state_t           state_q;
  state_t           state_d;
  logic             pop_q;
  logic [LEN_W-2:0] qw_cnt_q;
  logic             last_qw;
  logic             sop;
  logic             eop;
  logic [DATA_W-1:0] beat_data;

  assign last_qw = (qw_cnt_q == 1);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      S_IDLE:
        if (!cmd_empty_i)
          state_d = S_CHECK;
      S_CHECK:
        if (is_rd_i && tag_avail_i && room_i)
          state_d = S_HDR1;
        else if (is_wr_i && room_i)
          state_d = S_HDR1;
        else if (!is_rd_i && !is_wr_i)
          state_d = S_IDLE;
      S_HDR1:
        state_d = S_HDR2;
      S_HDR2:
        state_d = is_wr_i ? S_DATA : S_IDLE;
      S_DATA:
        if (!room_i)
          state_d = S_WAIT;
        else if (last_qw)
          state_d = S_IDLE;
      S_WAIT:
        if (room_i)
          state_d = S_DATA;
      default:
        state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      state_q  <= S_IDLE;
      pop_q    <= 1'b0;
      qw_cnt_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      pop_q   <= cmd_rd_req_o;
      // payload length in qwords
      if (state_q == S_CHECK)
        qw_cnt_q <= dw_len_i[LEN_W-1:1];
      else if (state_q == S_DATA && room_i)
        qw_cnt_q <= qw_cnt_q - 1'b1;
    end
  end

  assign cmd_rd_req_o  = (state_q == S_IDLE) && !cmd_empty_i;
  // only the first check cycle sees fresh FIFO data
  assign capture_o     = (state_q == S_CHECK) && pop_q;
  assign read_issued_o = (state_q == S_HDR1) && is_rd_i;

  // prefetch one qword ahead of each data beat
  assign wr_rd_req_o = ((state_q == S_HDR2) && is_wr_i) ||
                       ((state_q == S_DATA) && room_i && !last_qw);

  assign fifo_wr_o = (state_q == S_HDR1) || (state_q == S_HDR2) ||
                     ((state_q == S_DATA) && room_i);

  assign sop = (state_q == S_HDR1);
  assign eop = ((state_q == S_HDR2) && is_rd_i) || ((state_q == S_DATA) && last_qw);

  assign beat_data = (state_q == S_HDR1) ? hdr1_i :
                     (state_q == S_HDR2) ? hdr2_i : wr_data_i;

  assign fifo_beat_o = {eop, sop, beat_data};

  a_state_legal : assert property (
    @(posedge Clk_i) disable iff (!Rstn_i)
    state_q inside {S_IDLE, S_CHECK, S_HDR1, S_HDR2, S_DATA, S_WAIT}
  );

endmodule

// File: src/tx_read_tracker.sv
// one read slot freed per rising edge of cpl_buff_free_i, tag_avail lags the count
`timescale 1ns/10ps

module tx_read_tracker #(
  parameter int MAX_READS = 8
)
(
  input  logic Clk_i,
  input  logic Rstn_i,
  input  logic read_issued_i,
  input  logic cpl_buff_free_i,
  output logic tag_avail_o,
  output logic cpl_pending_o
);

  localparam int CNT_W = $clog2(MAX_READS + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             free_q;
  logic             cpl_rise;
  logic             tag_avail_q;

  assign cpl_rise = cpl_buff_free_i && !free_q;

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      cnt_q       <= CNT_W'(MAX_READS);
      free_q      <= 1'b0;
      tag_avail_q <= 1'b0;
    end
    else
    begin
      free_q      <= cpl_buff_free_i;
      tag_avail_q <= (cnt_q != '0);
      // issue and release together leave the count alone
      if (read_issued_i && !cpl_rise)
        cnt_q <= cnt_q - 1'b1;
      else if (cpl_rise && !read_issued_i)
        cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tag_avail_o   = tag_avail_q;
  assign cpl_pending_o = (cnt_q < CNT_W'(MAX_READS));

  a_cnt_max : assert property (
    @(posedge Clk_i) disable iff (!Rstn_i)
    cnt_q <= CNT_W'(MAX_READS)
  );

  a_cnt_min : assert property (
    @(posedge Clk_i) disable iff (!Rstn_i)
    (read_issued_i && !cpl_rise) |-> (cnt_q != '0)
  );

endmodule

// File: src/tx_out_fifo.sv
// FIFO_DEPTH must be a power of two, q_o is valid the cycle after rd_i
`timescale 1ns/10ps

module tx_out_fifo import tx_pkg::*;
#(
  parameter int FIFO_DEPTH = 16,
  parameter int ROOM_LEVEL = 4
)
(
  input  logic              Clk_i,
  input  logic              Rstn_i,
  input  logic              wr_i,
  input  logic [BEAT_W-1:0] beat_i,
  input  logic              rd_i,
  output logic [BEAT_W-1:0] q_o,
  output logic              empty_o,
  output logic              room_o
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [BEAT_W-1:0] mem [FIFO_DEPTH];
  logic [AW-1:0]     wr_ptr_q;
  logic [AW-1:0]     rd_ptr_q;
  logic [AW:0]       level_q;
  logic [BEAT_W-1:0] q_q;
  logic              room_q;

  always_ff @(posedge Clk_i)
  begin
    if (wr_i)
      mem[wr_ptr_q] <= beat_i;
    if (rd_i)
      q_q <= mem[rd_ptr_q];
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
      room_q   <= 1'b0;
    end
    else
    begin
      if (wr_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (wr_i && !rd_i)
        level_q <= level_q + 1'b1;
      else if (rd_i && !wr_i)
        level_q <= level_q - 1'b1;
      room_q <= (level_q <= (AW+1)'(ROOM_LEVEL));
    end
  end

  assign q_o     = q_q;
  assign empty_o = (level_q == '0);
  assign room_o  = room_q;

  a_no_overflow : assert property (
    @(posedge Clk_i) disable iff (!Rstn_i)
    wr_i |-> (level_q < (AW+1)'(FIFO_DEPTH))
  );

  a_no_underflow : assert property (
    @(posedge Clk_i) disable iff (!Rstn_i)
    rd_i |-> !empty_o
  );

endmodule

// File: src/tx_st_egress.sv
// ready is sampled one cycle late, so the sink must take a beat whenever valid is high
`timescale 1ns/10ps

module tx_st_egress import tx_pkg::*;
(
  input  logic              Clk_i,
  input  logic              Rstn_i,
  input  logic [BEAT_W-1:0] fifo_q_i,
  input  logic              fifo_empty_i,
  input  logic              tx_st_ready_i,
  output logic              fifo_rd_o,
  output logic              tx_st_valid_o,
  output logic [DATA_W-1:0] tx_st_data_o,
  output logic              tx_st_sop_o,
  output logic              tx_st_eop_o
);

  logic              ready_q;
  logic              fetch_valid_q;
  logic              out_valid_q;
  logic [DATA_W-1:0] data_q;
  logic              sop_q;
  logic              eop_q;
  logic              out_xfer;
  logic              fetch_xfer;

  // output stage drains on registered ready, fetch stage refills it
  assign out_xfer   = out_valid_q && ready_q;
  assign fetch_xfer = fetch_valid_q && (!out_valid_q || out_xfer);
  assign fifo_rd_o  = !fifo_empty_i && (!fetch_valid_q || fetch_xfer);

  always_ff @(posedge Clk_i)
  begin
    if (fetch_xfer)
      data_q <= fifo_q_i[DATA_W-1:0];
  end

  always_ff @(posedge Clk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      ready_q       <= 1'b0;
      fetch_valid_q <= 1'b0;
      out_valid_q   <= 1'b0;
      sop_q         <= 1'b0;
      eop_q         <= 1'b0;
    end
    else
    begin
      ready_q <= tx_st_ready_i;
      if (fifo_rd_o)
        fetch_valid_q <= 1'b1;
      else if (fetch_xfer)
        fetch_valid_q <= 1'b0;
      if (fetch_xfer)
      begin
        out_valid_q <= 1'b1;
        sop_q       <= fifo_q_i[DATA_W];
        eop_q       <= fifo_q_i[DATA_W+1];
      end
      else if (out_xfer)
      begin
        out_valid_q <= 1'b0;
        sop_q       <= 1'b0;
        eop_q       <= 1'b0;
      end
    end
  end

  assign tx_st_valid_o = out_xfer;
  assign tx_st_data_o  = data_q;
  assign tx_st_sop_o   = sop_q;
  assign tx_st_eop_o   = eop_q;

endmodule

// File: src/tx_top.sv
// memory read/write requests only, command and write-data FIFOs are not show-ahead
`timescale 1ns/10ps

module tx_top import tx_pkg::*;
#(
  parameter int MAX_READS  = 8,
  parameter int FIFO_DEPTH = 16,
  parameter int ROOM_LEVEL = 4
)
(
  input  logic                Clk_i,
  input  logic                Rstn_i,
  input  logic [BUSDEV_W-1:0] bus_dev_i,
  input  logic                cmd_empty_i,
  input  logic [CMD_W-1:0]    cmd_data_i,
  input  logic [DATA_W-1:0]   wr_data_i,
  input  logic                tx_st_ready_i,
  input  logic                cpl_buff_free_i,
  output logic                cmd_rd_req_o,
  output logic                wr_rd_req_o,
  output logic                tx_st_valid_o,
  output logic [DATA_W-1:0]   tx_st_data_o,
  output logic                tx_st_sop_o,
  output logic                tx_st_eop_o,
  output logic                cpl_pending_o
);

  logic              capture;
  logic              is_rd;
  logic              is_wr;
  logic [LEN_W-1:0]  dw_len;
  logic [DATA_W-1:0] hdr1;
  logic [DATA_W-1:0] hdr2;
  logic              read_issued;
  logic              tag_avail;
  logic              fifo_wr;
  logic [BEAT_W-1:0] fifo_beat;
  logic              room;
  logic              fifo_rd;
  logic [BEAT_W-1:0] fifo_q;
  logic              fifo_empty;

  tx_ctrl u_ctrl (
    .Clk_i         (Clk_i),
    .Rstn_i        (Rstn_i),
    .cmd_empty_i   (cmd_empty_i),
    .is_rd_i       (is_rd),
    .is_wr_i       (is_wr),
    .dw_len_i      (dw_len),
    .hdr1_i        (hdr1),
    .hdr2_i        (hdr2),
    .wr_data_i     (wr_data_i),
    .tag_avail_i   (tag_avail),
    .room_i        (room),
    .cmd_rd_req_o  (cmd_rd_req_o),
    .wr_rd_req_o   (wr_rd_req_o),
    .capture_o     (capture),
    .read_issued_o (read_issued),
    .fifo_wr_o     (fifo_wr),
    .fifo_beat_o   (fifo_beat)
  );

  tx_cmd_decode u_decode (
    .Clk_i      (Clk_i),
    .Rstn_i     (Rstn_i),
    .capture_i  (capture),
    .cmd_data_i (cmd_data_i),
    .bus_dev_i  (bus_dev_i),
    .is_rd_o    (is_rd),
    .is_wr_o    (is_wr),
    .dw_len_o   (dw_len),
    .hdr1_o     (hdr1),
    .hdr2_o     (hdr2)
  );

  tx_read_tracker #(
    .MAX_READS (MAX_READS)
  ) u_tracker (
    .Clk_i           (Clk_i),
    .Rstn_i          (Rstn_i),
    .read_issued_i   (read_issued),
    .cpl_buff_free_i (cpl_buff_free_i),
    .tag_avail_o     (tag_avail),
    .cpl_pending_o   (cpl_pending_o)
  );

  tx_out_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .ROOM_LEVEL (ROOM_LEVEL)
  ) u_out_fifo (
    .Clk_i   (Clk_i),
    .Rstn_i  (Rstn_i),
    .wr_i    (fifo_wr),
    .beat_i  (fifo_beat),
    .rd_i    (fifo_rd),
    .q_o     (fifo_q),
    .empty_o (fifo_empty),
    .room_o  (room)
  );

  tx_st_egress u_egress (
    .Clk_i         (Clk_i),
    .Rstn_i        (Rstn_i),
    .fifo_q_i      (fifo_q),
    .fifo_empty_i  (fifo_empty),
    .tx_st_ready_i (tx_st_ready_i),
    .fifo_rd_o     (fifo_rd),
    .tx_st_valid_o (tx_st_valid_o),
    .tx_st_data_o  (tx_st_data_o),
    .tx_st_sop_o   (tx_st_sop_o),
    .tx_st_eop_o   (tx_st_eop_o)
  );

endmodule

// File: bench/tb_clk_gen.sv
// 10 ns clock from time zero, reset low for 10 cycles and released 1 ns after a rising edge
`timescale 1ns/10ps

module tb_clk_gen
(
  output logic Clk_o,
  output logic Rstn_o
);

  initial
  begin
    Clk_o = 1'b0;
    forever #5 Clk_o = ~Clk_o;
  end

  initial
  begin
    Rstn_o = 1'b0;
    repeat (10) @(posedge Clk_o);
    #1 Rstn_o = 1'b1;
  end

endmodule

// File: bench/tb_top.sv
// FIFO models pop on a request seen at the falling edge and answer 1 ns after the next rise
`timescale 1ns/10ps

module tb_top import tx_pkg::*;
();

  localparam logic [BUSDEV_W-1:0] BUS_DEV = 13'h0a5;
  localparam int MAX_READS = 8;

  logic                Clk_i;
  logic                Rstn_i;
  logic [BUSDEV_W-1:0] bus_dev_i;
  logic                cmd_empty_i;
  logic [CMD_W-1:0]    cmd_data_i;
  logic [DATA_W-1:0]   wr_data_i;
  logic                tx_st_ready_i;
  logic                cpl_buff_free_i;
  logic                cmd_rd_req_o;
  logic                wr_rd_req_o;
  logic                tx_st_valid_o;
  logic [DATA_W-1:0]   tx_st_data_o;
  logic                tx_st_sop_o;
  logic                tx_st_eop_o;
  logic                cpl_pending_o;

  logic [BEAT_W-1:0] exp_q[$];
  logic [CMD_W-1:0]  cmd_fifo[$];
  logic [DATA_W-1:0] wdata_fifo[$];
  logic [BEAT_W-1:0] exp_beat;
  logic [31:0]       rng_state;
  string             test_name;
  logic              quiet_phase;
  logic              rand_ready;
  logic              ready_prev;
  int                beat_count;

  tb_clk_gen u_clk_gen (
    .Clk_o  (Clk_i),
    .Rstn_o (Rstn_i)
  );

  tx_top UUT (
    .Clk_i           (Clk_i),
    .Rstn_i          (Rstn_i),
    .bus_dev_i       (bus_dev_i),
    .cmd_empty_i     (cmd_empty_i),
    .cmd_data_i      (cmd_data_i),
    .wr_data_i       (wr_data_i),
    .tx_st_ready_i   (tx_st_ready_i),
    .cpl_buff_free_i (cpl_buff_free_i),
    .cmd_rd_req_o    (cmd_rd_req_o),
    .wr_rd_req_o     (wr_rd_req_o),
    .tx_st_valid_o   (tx_st_valid_o),
    .tx_st_data_o    (tx_st_data_o),
    .tx_st_sop_o     (tx_st_sop_o),
    .tx_st_eop_o     (tx_st_eop_o),
    .cpl_pending_o   (cpl_pending_o)
  );

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input logic [BEAT_W-1:0] expected,
                                 input logic [BEAT_W-1:0] actual);
    $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_failure(input string msg);
    $display("error in test %s: %s", test_name, msg);
    stop_with_failure();
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // 3-DW request header, DW0 in the low half
  function automatic logic [DATA_W-1:0] header_qw1(input tx_cmd_t c);
    logic [31:0] dw0;
    logic [31:0] dw1;
    dw0 = {(c.is_wr ? FMT_MWR32 : FMT_MRD32), 14'h0, c.dw_len};
    dw1 = {BUS_DEV, 3'b000, c.tag, c.lbe, c.fbe};
    return {dw1, dw0};
  endfunction

  task automatic tick();
    logic [31:0] r;
    @(posedge Clk_i);
    #1;
    if (rand_ready)
    begin
      r = next_rand();
      // ready about three cycles in four
      tx_st_ready_i = r[0] | r[1];
    end
  endtask

  task automatic queue_cmd(input logic rd, input logic [LEN_W-1:0] len);
    tx_cmd_t           c;
    logic [31:0]       r;
    logic [31:0]       hi;
    logic [31:0]       lo;
    logic [DATA_W-1:0] qw;
    int                n;
    quiet_phase = 1'b0;
    r = next_rand();
    c.addr = {r[31:3], 3'b000};
    r = next_rand();
    c.tag    = r[7:0];
    c.fbe    = r[11:8];
    c.lbe    = r[15:12];
    c.is_rd  = rd;
    c.is_wr  = !rd;
    c.dw_len = len;
    cmd_fifo.push_back(c);
    exp_q.push_back({1'b0, 1'b1, header_qw1(c)});
    exp_q.push_back({rd, 1'b0, 32'h0, c.addr});
    if (!rd)
    begin
      n = int'(len) / 2;
      for (int i = 0; i < n; i++)
      begin
        hi = next_rand();
        lo = next_rand();
        qw = {hi, lo};
        wdata_fifo.push_back(qw);
        exp_q.push_back({(i == n - 1), 1'b0, qw});
      end
    end
  endtask

  task automatic wait_reset(input int limit);
    int cycles;
    cycles = 0;
    while (!Rstn_i && cycles < limit)
    begin
      @(negedge Clk_i);
      cycles++;
    end
    if (!Rstn_i)
      report_failure("reset was never released");
  endtask

  // wait until only the given number of expected beats is left
  task automatic wait_expected(input int remaining, input int limit);
    int cycles;
    cycles = 0;
    while (exp_q.size() > remaining && cycles < limit)
    begin
      tick();
      cycles++;
    end
    if (exp_q.size() > remaining)
      report_failure("timeout waiting for output beats");
  endtask

  task automatic free_reads(input int n);
    for (int i = 0; i < n; i++)
    begin
      tick();
      cpl_buff_free_i = 1'b1;
      tick();
      cpl_buff_free_i = 1'b0;
    end
    repeat (3) tick();
  endtask

  // command and write-data FIFO models
  initial
  begin
    logic [CMD_W-1:0]  cmd_next;
    logic [DATA_W-1:0] wdata_next;
    logic              empty_next;
    cmd_empty_i = 1'b1;
    cmd_data_i  = '0;
    wr_data_i   = '0;
    cmd_next    = '0;
    wdata_next  = '0;
    forever
    begin
      @(negedge Clk_i);
      if (cmd_rd_req_o)
      begin
        assert (cmd_fifo.size() > 0)
          else report_failure("command FIFO read while empty");
        cmd_next = cmd_fifo.pop_front();
      end
      if (wr_rd_req_o)
      begin
        assert (wdata_fifo.size() > 0)
          else report_failure("write-data FIFO read while empty");
        wdata_next = wdata_fifo.pop_front();
      end
      empty_next = (cmd_fifo.size() == 0);
      @(posedge Clk_i);
      #1;
      cmd_data_i  = cmd_next;
      wr_data_i   = wdata_next;
      cmd_empty_i = empty_next;
    end
  end

  // output monitor and scoreboard
  initial
  begin
    ready_prev = 1'b0;
    beat_count = 0;
    forever
    begin
      @(negedge Clk_i);
      if (Rstn_i && quiet_phase)
        assert (!cmd_rd_req_o && !wr_rd_req_o && !tx_st_valid_o && !tx_st_sop_o &&
                !tx_st_eop_o && !cpl_pending_o)
          else report_failure("an output left its reset level before the first command");
      if (Rstn_i && tx_st_valid_o)
      begin
        assert (ready_prev)
          else report_failure("valid beat without ready in the previous cycle");
        assert (exp_q.size() > 0)
          else report_failure("valid beat when no beat was expected");
        exp_beat = exp_q.pop_front();
        assert ({tx_st_eop_o, tx_st_sop_o, tx_st_data_o} == exp_beat)
          else report_mismatch(exp_beat, {tx_st_eop_o, tx_st_sop_o, tx_st_data_o});
        beat_count++;
      end
      ready_prev = tx_st_ready_i;
    end
  end

  initial
  begin
    logic [31:0]      r;
    logic [LEN_W-1:0] len;
    int               reads;
    int               count;
    rng_state       = 32'ha289;
    rand_ready      = 1'b0;
    quiet_phase     = 1'b1;
    test_name       = "reset";
    bus_dev_i       = BUS_DEV;
    tx_st_ready_i   = 1'b0;
    cpl_buff_free_i = 1'b0;
    wait_reset(50);
    repeat (20) tick();

    test_name = "read";
    tx_st_ready_i = 1'b1;
    queue_cmd(1'b1, LEN_W'(4));
    wait_expected(0, 200);
    free_reads(1);
    assert (!cpl_pending_o)
      else report_mismatch('0, BEAT_W'(cpl_pending_o));

    test_name = "write";
    queue_cmd(1'b0, LEN_W'(2));
    queue_cmd(1'b0, LEN_W'(16));
    queue_cmd(1'b0, LEN_W'(8));
    wait_expected(0, 400);

    // mixed traffic under random back-pressure, reads stay below the limit
    test_name = "random";
    rand_ready = 1'b1;
    reads = 0;
    for (int i = 0; i < 24; i++)
    begin
      r = next_rand();
      len = LEN_W'({r[4:2], 1'b0}) + LEN_W'(2);
      if (r[0] && reads < 6)
      begin
        reads++;
        queue_cmd(1'b1, len);
      end
      else
        queue_cmd(1'b0, len);
      repeat (int'(r[9:8])) tick();
    end
    wait_expected(0, 3000);
    rand_ready = 1'b0;
    tx_st_ready_i = 1'b1;
    free_reads(reads);
    assert (!cpl_pending_o)
      else report_mismatch('0, BEAT_W'(cpl_pending_o));

    test_name = "read_limit";
    for (int i = 0; i <= MAX_READS; i++)
      queue_cmd(1'b1, LEN_W'(2));
    wait_expected(2, 600);
    assert (cpl_pending_o)
      else report_mismatch(BEAT_W'(1), BEAT_W'(cpl_pending_o));
    count = beat_count;
    repeat (100) tick();
    assert (beat_count == count)
      else report_failure("a read went out past the outstanding-read limit");
    free_reads(1);
    wait_expected(0, 100);
    free_reads(MAX_READS);
    assert (!cpl_pending_o)
      else report_mismatch('0, BEAT_W'(cpl_pending_o));

    repeat (5) tick();
    if (exp_q.size() == 0 && cmd_fifo.size() == 0 && wdata_fifo.size() == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
      report_failure("beats or FIFO entries were left over at the end of the run");
  end

endmodule

// File: files.f
src/tx_pkg.sv
src/tx_cmd_decode.sv
src/tx_ctrl.sv
src/tx_read_tracker.sv
src/tx_out_fifo.sv
src/tx_st_egress.sv
src/tx_top.sv
bench/tb_clk_gen.sv
bench/tb_top.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_top
FILELIST   := files.f
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
LOG        := sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
